//--- hdl/cpu_isa_pkg.sv
package cpu_isa_pkg;

typedef logic [31:0] uint32_t;
typedef logic [31:0] virt_t;
typedef logic [4:0]  reg_addr_t;
typedef logic [63:0] uint64_t;
typedef logic [4:0]  shamt_t;
typedef logic [5:0]  opcode_t;
typedef logic [5:0]  funct_t;

localparam int REG_NUM = 32;
localparam virt_t RESET_PC = 32'h0000_0000;

// low bit of each instruction field
localparam int OPCODE_LSB = 26;
localparam int RS_LSB     = 21;
localparam int RT_LSB     = 16;
localparam int RD_LSB     = 11;
localparam int SA_LSB     = 6;

localparam opcode_t OPC_SPECIAL = 6'h00;
localparam opcode_t OPC_BEQ     = 6'h04;
localparam opcode_t OPC_BNE     = 6'h05;
localparam opcode_t OPC_ADDIU   = 6'h09;
localparam opcode_t OPC_ORI     = 6'h0d;
localparam opcode_t OPC_LUI     = 6'h0f;
localparam opcode_t OPC_LW      = 6'h23;
localparam opcode_t OPC_SW      = 6'h2b;

// function field of SPECIAL
localparam funct_t FN_SLL  = 6'h00;
localparam funct_t FN_MFHI = 6'h10;
localparam funct_t FN_MFLO = 6'h12;
localparam funct_t FN_MULT = 6'h18;
localparam funct_t FN_ADDU = 6'h21;
localparam funct_t FN_SUBU = 6'h23;
localparam funct_t FN_AND  = 6'h24;
localparam funct_t FN_OR   = 6'h25;
localparam funct_t FN_XOR  = 6'h26;
localparam funct_t FN_SLT  = 6'h2a;

typedef enum logic [4:0] {
	OP_NOP, OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLL,
	OP_ADDIU, OP_ORI, OP_LUI, OP_LW, OP_SW, OP_BEQ, OP_BNE,
	OP_MULT, OP_MFHI, OP_MFLO
} op_t;

endpackage

//--- hdl/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

typedef struct packed {
	logic               read;
	cpu_isa_pkg::virt_t address;
} ibus_req_t;

typedef struct packed {
	logic                 valid;
	cpu_isa_pkg::uint32_t rddata;
} ibus_resp_t;

typedef struct packed {
	logic                 read;
	logic                 write;
	cpu_isa_pkg::virt_t   address;
	cpu_isa_pkg::uint32_t wrdata;
} dbus_req_t;

typedef struct packed {
	logic                 stall;
	cpu_isa_pkg::uint32_t rddata;
} dbus_resp_t;

typedef struct packed {
	logic                 valid;
	cpu_isa_pkg::virt_t   pc;
	cpu_isa_pkg::uint32_t instr;
} fetch_entry_t;

// operands are already forwarded, imm already extended
typedef struct packed {
	logic                   valid;
	cpu_isa_pkg::op_t       op;
	cpu_isa_pkg::reg_addr_t rd;
	cpu_isa_pkg::uint32_t   op0;
	cpu_isa_pkg::uint32_t   op1;
	cpu_isa_pkg::uint32_t   imm;
	cpu_isa_pkg::shamt_t    shamt;
	cpu_isa_pkg::virt_t     branch_target;
} pipeline_decode_t;

typedef struct packed {
	logic                   valid;
	cpu_isa_pkg::reg_addr_t rd;
	cpu_isa_pkg::uint32_t   result;
	logic                   is_load;
	logic                   write_reg;
} pipeline_exec_t;

typedef struct packed {
	logic               taken;
	cpu_isa_pkg::virt_t target;
} branch_resolved_t;

typedef enum logic [1:0] {
	FETCH_IDLE,
	FETCH_WAIT,
	FETCH_DROP
} fetch_state_t;

endpackage

//--- hdl/regfile.sv
module regfile (
	input  logic                         clk,
	input  logic                         rst,
	input  cpu_isa_pkg::reg_addr_t [1:0] raddr,
	output cpu_isa_pkg::uint32_t   [1:0] rdata,
	input  logic                         we,
	input  cpu_isa_pkg::reg_addr_t       waddr,
	input  cpu_isa_pkg::uint32_t         wdata
);

cpu_isa_pkg::uint32_t [cpu_isa_pkg::REG_NUM-1:0] regs;

always_ff @(posedge clk) begin
	if (rst) begin
		regs <= '0;
	end else if (we && waddr != '0) begin
		regs[waddr] <= wdata;
	end
end

// write-through so a value written this cycle is seen by decode
always_comb begin
	for (int p = 0; p < 2; p++) begin
		if (raddr[p] == '0)
			rdata[p] = '0;
		else if (we && waddr == raddr[p])
			rdata[p] = wdata;
		else
			rdata[p] = regs[raddr[p]];
	end
end

// decode maps writes to $0 onto no write at all
assert property (@(posedge clk) disable iff (rst) !(we && waddr == '0 && wdata != '0));

endmodule

//--- hdl/instr_fetch.sv
module instr_fetch (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           stall,
	input  cpu_pipe_pkg::branch_resolved_t resolved_branch,
	output cpu_pipe_pkg::ibus_req_t        ibus_req,
	input  cpu_pipe_pkg::ibus_resp_t       ibus_resp,
	output cpu_pipe_pkg::fetch_entry_t     fetch_entry
);

cpu_pipe_pkg::fetch_state_t state;
cpu_isa_pkg::virt_t         pc;
cpu_isa_pkg::virt_t         req_addr;
logic                       can_load;
logic                       issue;
logic                       resp_ok;

// entry is free or gets consumed by decode this cycle
assign can_load = ~stall | ~fetch_entry.valid;
assign issue    = state == cpu_pipe_pkg::FETCH_IDLE && can_load && ~resolved_branch.taken;
assign resp_ok  = ibus_resp.valid && can_load &&
	(issue || state == cpu_pipe_pkg::FETCH_WAIT);

assign ibus_req.read    = issue || state != cpu_pipe_pkg::FETCH_IDLE;
assign ibus_req.address = (state == cpu_pipe_pkg::FETCH_IDLE) ? pc : req_addr;

always_ff @(posedge clk) begin
	if (rst) begin
		state       <= cpu_pipe_pkg::FETCH_IDLE;
		pc          <= cpu_isa_pkg::RESET_PC;
		req_addr    <= cpu_isa_pkg::RESET_PC;
		fetch_entry <= '0;
	end else if (resolved_branch.taken) begin
		pc                <= resolved_branch.target;
		fetch_entry.valid <= 1'b0;
		// an outstanding read must still complete, its data is thrown away
		if (state != cpu_pipe_pkg::FETCH_IDLE && ~ibus_resp.valid)
			state <= cpu_pipe_pkg::FETCH_DROP;
		else
			state <= cpu_pipe_pkg::FETCH_IDLE;
	end else begin
		if (can_load)
			fetch_entry.valid <= 1'b0;
		// a response that finds the entry blocked is refetched later
		if (resp_ok) begin
			fetch_entry <= '{valid: 1'b1, pc: pc, instr: ibus_resp.rddata};
			pc          <= pc + 32'd4;
		end
		if (issue)
			req_addr <= pc;
		case (state)
			cpu_pipe_pkg::FETCH_IDLE:
				if (issue && ~ibus_resp.valid)
					state <= cpu_pipe_pkg::FETCH_WAIT;
			cpu_pipe_pkg::FETCH_WAIT, cpu_pipe_pkg::FETCH_DROP:
				if (ibus_resp.valid)
					state <= cpu_pipe_pkg::FETCH_IDLE;
			default:
				state <= cpu_pipe_pkg::FETCH_IDLE;
		endcase
	end
end

assert property (@(posedge clk) disable iff (rst)
	state == cpu_pipe_pkg::FETCH_WAIT && ~ibus_resp.valid |=>
	ibus_req.read && $stable(ibus_req.address));

endmodule

//--- hdl/decode_issue.sv
module decode_issue (
	input  cpu_pipe_pkg::fetch_entry_t     fetch_entry,
	output cpu_isa_pkg::reg_addr_t [1:0]   reg_raddr,
	input  cpu_isa_pkg::uint32_t   [1:0]   reg_rdata,
	input  cpu_pipe_pkg::pipeline_exec_t   pipeline_exec,
	input  cpu_pipe_pkg::pipeline_exec_t   pipeline_wb,
	input  cpu_isa_pkg::uint32_t           wb_data,
	output cpu_pipe_pkg::pipeline_decode_t pipeline_decode,
	output logic                           stall_req
);

cpu_isa_pkg::opcode_t         opcode;
cpu_isa_pkg::funct_t          funct;
cpu_isa_pkg::reg_addr_t       rs, rt, rd_field;
cpu_isa_pkg::uint32_t         imm_sext;
cpu_isa_pkg::op_t             op;
cpu_isa_pkg::uint32_t   [1:0] operand;
logic                         uses_rs, uses_rt;

assign opcode   = fetch_entry.instr[cpu_isa_pkg::OPCODE_LSB +: 6];
assign funct    = fetch_entry.instr[5:0];
assign rs       = fetch_entry.instr[cpu_isa_pkg::RS_LSB +: 5];
assign rt       = fetch_entry.instr[cpu_isa_pkg::RT_LSB +: 5];
assign rd_field = fetch_entry.instr[cpu_isa_pkg::RD_LSB +: 5];
assign imm_sext = {{16{fetch_entry.instr[15]}}, fetch_entry.instr[15:0]};

assign reg_raddr[0] = rs;
assign reg_raddr[1] = rt;

always_comb begin
	case (opcode)
		cpu_isa_pkg::OPC_SPECIAL:
			case (funct)
				cpu_isa_pkg::FN_ADDU: op = cpu_isa_pkg::OP_ADDU;
				cpu_isa_pkg::FN_SUBU: op = cpu_isa_pkg::OP_SUBU;
				cpu_isa_pkg::FN_AND:  op = cpu_isa_pkg::OP_AND;
				cpu_isa_pkg::FN_OR:   op = cpu_isa_pkg::OP_OR;
				cpu_isa_pkg::FN_XOR:  op = cpu_isa_pkg::OP_XOR;
				cpu_isa_pkg::FN_SLT:  op = cpu_isa_pkg::OP_SLT;
				cpu_isa_pkg::FN_SLL:  op = cpu_isa_pkg::OP_SLL;
				cpu_isa_pkg::FN_MULT: op = cpu_isa_pkg::OP_MULT;
				cpu_isa_pkg::FN_MFHI: op = cpu_isa_pkg::OP_MFHI;
				cpu_isa_pkg::FN_MFLO: op = cpu_isa_pkg::OP_MFLO;
				default:              op = cpu_isa_pkg::OP_NOP;
			endcase
		cpu_isa_pkg::OPC_ADDIU: op = cpu_isa_pkg::OP_ADDIU;
		cpu_isa_pkg::OPC_ORI:   op = cpu_isa_pkg::OP_ORI;
		cpu_isa_pkg::OPC_LUI:   op = cpu_isa_pkg::OP_LUI;
		cpu_isa_pkg::OPC_LW:    op = cpu_isa_pkg::OP_LW;
		cpu_isa_pkg::OPC_SW:    op = cpu_isa_pkg::OP_SW;
		cpu_isa_pkg::OPC_BEQ:   op = cpu_isa_pkg::OP_BEQ;
		cpu_isa_pkg::OPC_BNE:   op = cpu_isa_pkg::OP_BNE;
		default:                op = cpu_isa_pkg::OP_NOP;
	endcase
end

// which source registers the operation really reads
always_comb begin
	uses_rs = 1'b1;
	case (op)
		cpu_isa_pkg::OP_SLL, cpu_isa_pkg::OP_LUI, cpu_isa_pkg::OP_MFHI,
		cpu_isa_pkg::OP_MFLO, cpu_isa_pkg::OP_NOP: uses_rs = 1'b0;
		default: uses_rs = 1'b1;
	endcase
	case (op)
		cpu_isa_pkg::OP_ADDIU, cpu_isa_pkg::OP_ORI, cpu_isa_pkg::OP_LUI, cpu_isa_pkg::OP_LW,
		cpu_isa_pkg::OP_MFHI, cpu_isa_pkg::OP_MFLO, cpu_isa_pkg::OP_NOP: uses_rt = 1'b0;
		default: uses_rt = 1'b1;
	endcase
end

// newest value first: execute, then write-back, then register file
always_comb begin
	for (int i = 0; i < 2; i++) begin
		if (pipeline_exec.write_reg && pipeline_exec.rd == reg_raddr[i])
			operand[i] = pipeline_exec.result;
		else if (pipeline_wb.write_reg && pipeline_wb.rd == reg_raddr[i])
			operand[i] = wb_data;
		else
			operand[i] = reg_rdata[i];
	end
end

assign stall_req = fetch_entry.valid && pipeline_exec.is_load && pipeline_exec.write_reg &&
	((uses_rs && pipeline_exec.rd == rs) || (uses_rt && pipeline_exec.rd == rt));

always_comb begin
	pipeline_decode.valid         = fetch_entry.valid;
	pipeline_decode.op            = op;
	pipeline_decode.op0           = operand[0];
	pipeline_decode.op1           = operand[1];
	pipeline_decode.imm           = imm_sext;
	pipeline_decode.shamt         = fetch_entry.instr[cpu_isa_pkg::SA_LSB +: 5];
	pipeline_decode.branch_target = fetch_entry.pc + 32'd4 + {imm_sext[29:0], 2'b00};
	case (op)
		cpu_isa_pkg::OP_ADDU, cpu_isa_pkg::OP_SUBU, cpu_isa_pkg::OP_AND, cpu_isa_pkg::OP_OR,
		cpu_isa_pkg::OP_XOR, cpu_isa_pkg::OP_SLT, cpu_isa_pkg::OP_SLL,
		cpu_isa_pkg::OP_MFHI, cpu_isa_pkg::OP_MFLO: pipeline_decode.rd = rd_field;
		cpu_isa_pkg::OP_ADDIU, cpu_isa_pkg::OP_LW: pipeline_decode.rd = rt;
		cpu_isa_pkg::OP_ORI: begin
			pipeline_decode.rd  = rt;
			pipeline_decode.imm = {16'h0000, fetch_entry.instr[15:0]};
		end
		cpu_isa_pkg::OP_LUI: begin
			pipeline_decode.rd  = rt;
			pipeline_decode.imm = {fetch_entry.instr[15:0], 16'h0000};
		end
		default: pipeline_decode.rd = '0;
	endcase
end

endmodule

//--- hdl/instr_exec.sv
module instr_exec (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           stall,
	input  cpu_pipe_pkg::pipeline_decode_t data,
	output cpu_pipe_pkg::pipeline_exec_t   result,
	output cpu_pipe_pkg::branch_resolved_t resolved_branch,
	output cpu_pipe_pkg::dbus_req_t        dbus_req
);

cpu_isa_pkg::uint64_t hilo;
cpu_isa_pkg::uint64_t product;
cpu_isa_pkg::uint32_t alu_out;
logic                 is_load;
logic                 is_store;
logic                 operands_equal;

// operands sign-extended to the 64-bit context
assign product = $signed(data.op0) * $signed(data.op1);

always_comb begin
	case (data.op)
		cpu_isa_pkg::OP_ADDU:  alu_out = data.op0 + data.op1;
		cpu_isa_pkg::OP_SUBU:  alu_out = data.op0 - data.op1;
		cpu_isa_pkg::OP_AND:   alu_out = data.op0 & data.op1;
		cpu_isa_pkg::OP_OR:    alu_out = data.op0 | data.op1;
		cpu_isa_pkg::OP_XOR:   alu_out = data.op0 ^ data.op1;
		cpu_isa_pkg::OP_SLT:   alu_out = {31'b0, $signed(data.op0) < $signed(data.op1)};
		cpu_isa_pkg::OP_SLL:   alu_out = data.op1 << data.shamt;
		cpu_isa_pkg::OP_ORI:   alu_out = data.op0 | data.imm;
		cpu_isa_pkg::OP_LUI:   alu_out = data.imm;
		cpu_isa_pkg::OP_MFHI:  alu_out = hilo[63:32];
		cpu_isa_pkg::OP_MFLO:  alu_out = hilo[31:0];
		// ADDIU and the load/store address
		cpu_isa_pkg::OP_ADDIU, cpu_isa_pkg::OP_LW, cpu_isa_pkg::OP_SW:
			alu_out = data.op0 + data.imm;
		default: alu_out = '0;
	endcase
end

// product lands here, so a following MFHI/MFLO sees it without forwarding
always_ff @(posedge clk) begin
	if (rst)
		hilo <= '0;
	else if (data.valid && data.op == cpu_isa_pkg::OP_MULT && ~stall)
		hilo <= product;
end

assign operands_equal = data.op0 == data.op1;
assign resolved_branch.taken = data.valid && ~stall &&
	((data.op == cpu_isa_pkg::OP_BEQ && operands_equal) ||
	 (data.op == cpu_isa_pkg::OP_BNE && ~operands_equal));
assign resolved_branch.target = data.branch_target;

assign is_load  = data.valid && data.op == cpu_isa_pkg::OP_LW;
assign is_store = data.valid && data.op == cpu_isa_pkg::OP_SW;

assign dbus_req.read    = is_load;
assign dbus_req.write   = is_store;
assign dbus_req.address = alu_out;
assign dbus_req.wrdata  = data.op1;

assign result.valid     = data.valid;
assign result.rd        = data.rd;
assign result.result    = alu_out;
assign result.is_load   = is_load;
assign result.write_reg = data.valid && data.rd != '0;

assert property (@(posedge clk) disable iff (rst) !(dbus_req.read && dbus_req.write));

// the core must hold ID/EX while the bus stalls
assert property (@(posedge clk) disable iff (rst)
	(dbus_req.read || dbus_req.write) && stall |=> $stable(dbus_req));

endmodule

//--- hdl/cpu_core.sv
module cpu_core (
	input  logic                     clk,
	input  logic                     rst,
	output cpu_pipe_pkg::ibus_req_t  ibus_req,
	input  cpu_pipe_pkg::ibus_resp_t ibus_resp,
	output cpu_pipe_pkg::dbus_req_t  dbus_req,
	input  cpu_pipe_pkg::dbus_resp_t dbus_resp
);

cpu_pipe_pkg::fetch_entry_t     fetch_entry;
cpu_pipe_pkg::pipeline_decode_t pipeline_decode, pipeline_decode_d;
cpu_pipe_pkg::pipeline_exec_t   pipeline_exec, pipeline_wb;
cpu_pipe_pkg::branch_resolved_t resolved_branch;
cpu_isa_pkg::reg_addr_t [1:0]   reg_raddr;
cpu_isa_pkg::uint32_t   [1:0]   reg_rdata;
cpu_isa_pkg::uint32_t           wb_data;
logic                           stall_from_id;
logic                           stall_mem;
logic                           stall_if;

assign stall_mem = dbus_resp.stall;
assign stall_if  = stall_from_id | stall_mem;

instr_fetch instr_fetch_inst (
	.clk,
	.rst,
	.stall           ( stall_if        ),
	.resolved_branch ( resolved_branch ),
	.ibus_req        ( ibus_req        ),
	.ibus_resp       ( ibus_resp       ),
	.fetch_entry     ( fetch_entry     )
);

decode_issue decode_issue_inst (
	.fetch_entry     ( fetch_entry     ),
	.reg_raddr       ( reg_raddr       ),
	.reg_rdata       ( reg_rdata       ),
	.pipeline_exec   ( pipeline_exec   ),
	.pipeline_wb     ( pipeline_wb     ),
	.wb_data         ( wb_data         ),
	.pipeline_decode ( pipeline_decode ),
	.stall_req       ( stall_from_id   )
);

// ID/EX, a load-use stall leaves a bubble behind
always_ff @(posedge clk) begin
	if (rst || resolved_branch.taken)
		pipeline_decode_d <= '0;
	else if (~stall_mem && stall_from_id)
		pipeline_decode_d <= '0;
	else if (~stall_mem)
		pipeline_decode_d <= pipeline_decode;
end

instr_exec instr_exec_inst (
	.clk,
	.rst,
	.stall           ( stall_mem         ),
	.data            ( pipeline_decode_d ),
	.result          ( pipeline_exec     ),
	.resolved_branch ( resolved_branch   ),
	.dbus_req        ( dbus_req          )
);

// EX/WB; the write-back entry retires during a bus stall, so it goes empty
always_ff @(posedge clk) begin
	if (rst || stall_mem)
		pipeline_wb <= '0;
	else
		pipeline_wb <= pipeline_exec;
end

assign wb_data = pipeline_wb.is_load ? dbus_resp.rddata : pipeline_wb.result;

regfile regfile_inst (
	.clk,
	.rst,
	.raddr ( reg_raddr             ),
	.rdata ( reg_rdata             ),
	.we    ( pipeline_wb.write_reg ),
	.waddr ( pipeline_wb.rd        ),
	.wdata ( wb_data               )
);

endmodule

//--- bench/cpu_ref_model.svh
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// instruction encoders
function automatic cpu_isa_pkg::uint32_t rtype(cpu_isa_pkg::funct_t fn, int rs, int rt, int rd,
	int sa);
	return {cpu_isa_pkg::OPC_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
endfunction

function automatic cpu_isa_pkg::uint32_t itype(cpu_isa_pkg::opcode_t opc, int rs, int rt,
	int imm);
	return {opc, 5'(rs), 5'(rt), 16'(imm)};
endfunction

task automatic emit(cpu_isa_pkg::uint32_t word);
	imem[prog_len] = word;
	prog_len++;
endtask

task automatic begin_program();
	for (int i = 0; i < MEM_WORDS; i++)
		imem[i] = '0;
	prog_len = 0;
endtask

// final self-branch marks the end of the program
task automatic end_program();
	end_pc = prog_len * 4;
	emit(itype(cpu_isa_pkg::OPC_BEQ, 0, 0, -1));
endtask

task automatic store_reg(int rt, int addr);
	emit(itype(cpu_isa_pkg::OPC_SW, 0, rt, addr));
endtask

// ISA interpreter over ref_dmem, records the store list
function automatic void run_ref();
	cpu_isa_pkg::uint32_t regs [32];
	cpu_isa_pkg::uint64_t hilo;
	cpu_isa_pkg::virt_t   pc;
	cpu_isa_pkg::virt_t   pc_next;
	cpu_isa_pkg::uint32_t ins;
	cpu_isa_pkg::uint32_t a;
	cpu_isa_pkg::uint32_t b;
	cpu_isa_pkg::uint32_t imm_s;
	cpu_isa_pkg::uint32_t res;
	cpu_isa_pkg::uint32_t addr;
	int                   dest;
	for (int i = 0; i < 32; i++)
		regs[i] = '0;
	hilo = '0;
	pc = cpu_isa_pkg::RESET_PC;
	ref_addr_q.delete();
	ref_data_q.delete();
	for (int step = 0; step < 20000 && pc != end_pc; step++) begin
		ins = imem[pc[9:2]];
		a = regs[ins[25:21]];
		b = regs[ins[20:16]];
		imm_s = {{16{ins[15]}}, ins[15:0]};
		addr = a + imm_s;
		pc_next = pc + 4;
		dest = 0;
		res = '0;
		case (ins[31:26])
			cpu_isa_pkg::OPC_SPECIAL: begin
				dest = ins[15:11];
				case (ins[5:0])
					cpu_isa_pkg::FN_ADDU: res = a + b;
					cpu_isa_pkg::FN_SUBU: res = a - b;
					cpu_isa_pkg::FN_AND:  res = a & b;
					cpu_isa_pkg::FN_OR:   res = a | b;
					cpu_isa_pkg::FN_XOR:  res = a ^ b;
					cpu_isa_pkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 1 : 0;
					cpu_isa_pkg::FN_SLL:  res = b << ins[10:6];
					cpu_isa_pkg::FN_MFHI: res = hilo[63:32];
					cpu_isa_pkg::FN_MFLO: res = hilo[31:0];
					cpu_isa_pkg::FN_MULT: begin
						hilo = {{32{a[31]}}, a} * {{32{b[31]}}, b};
						dest = 0;
					end
					default: dest = 0;
				endcase
			end
			cpu_isa_pkg::OPC_ADDIU: begin
				dest = ins[20:16];
				res = addr;
			end
			cpu_isa_pkg::OPC_ORI: begin
				dest = ins[20:16];
				res = a | {16'h0000, ins[15:0]};
			end
			cpu_isa_pkg::OPC_LUI: begin
				dest = ins[20:16];
				res = {ins[15:0], 16'h0000};
			end
			cpu_isa_pkg::OPC_LW: begin
				dest = ins[20:16];
				res = ref_dmem[addr[9:2]];
			end
			cpu_isa_pkg::OPC_SW: begin
				ref_dmem[addr[9:2]] = b;
				ref_addr_q.push_back(addr);
				ref_data_q.push_back(b);
			end
			cpu_isa_pkg::OPC_BEQ:
				if (a == b)
					pc_next = pc + 4 + {imm_s[29:0], 2'b00};
			cpu_isa_pkg::OPC_BNE:
				if (a != b)
					pc_next = pc + 4 + {imm_s[29:0], 2'b00};
			default: dest = 0;
		endcase
		if (dest != 0)
			regs[dest] = res;
		pc = pc_next;
	end
endfunction

`endif

//--- bench/cpu_core_tb.sv
module cpu_core_tb;

localparam int MEM_WORDS = 256;

logic                     clk;
logic                     rst;
cpu_pipe_pkg::ibus_req_t  ibus_req;
cpu_pipe_pkg::ibus_resp_t ibus_resp;
cpu_pipe_pkg::dbus_req_t  dbus_req;
cpu_pipe_pkg::dbus_resp_t dbus_resp;

cpu_isa_pkg::uint32_t imem [MEM_WORDS];
cpu_isa_pkg::uint32_t dmem [MEM_WORDS];
cpu_isa_pkg::uint32_t ref_dmem [MEM_WORDS];
cpu_isa_pkg::uint32_t ref_addr_q [$];
cpu_isa_pkg::uint32_t ref_data_q [$];
cpu_isa_pkg::uint32_t dut_addr_q [$];
cpu_isa_pkg::uint32_t dut_data_q [$];
int                   prog_len;
cpu_isa_pkg::virt_t   end_pc;
int                   ibus_wait;
logic                 ibus_delay_en;
logic                 dbus_stall_en;
logic                 end_seen;
logic                 compare_start;
logic                 compare_done;
int                   errors;
int                   checks;

`include "cpu_ref_model.svh"

cpu_core cpu_core_inst (
	.clk,
	.rst,
	.ibus_req  ( ibus_req  ),
	.ibus_resp ( ibus_resp ),
	.dbus_req  ( dbus_req  ),
	.dbus_resp ( dbus_resp )
);

initial begin
	clk = 1'b0;
	forever #50 clk = ~clk;
end

// instruction memory answers once the wait count runs out
always_comb begin
	ibus_resp.valid  = ibus_req.read && ibus_wait == 0;
	ibus_resp.rddata = imem[ibus_req.address[9:2]];
end

always @(posedge clk) begin
	if (rst)
		ibus_wait <= 0;
	else if (ibus_req.read && ibus_resp.valid)
		ibus_wait <= ibus_delay_en ? int'($urandom % 3) : 0;
	else if (ibus_wait > 0)
		ibus_wait <= ibus_wait - 1;
end

// data memory, store monitor and end detection
always @(posedge clk) begin
	if (rst) begin
		dbus_resp.stall <= 1'b0;
		end_seen <= 1'b0;
	end else begin
		dbus_resp.stall <= dbus_stall_en && ($urandom % 4 == 0);
		if (dbus_req.read && !dbus_resp.stall)
			dbus_resp.rddata <= dmem[dbus_req.address[9:2]];
		if (dbus_req.write && !dbus_resp.stall) begin
			dmem[dbus_req.address[9:2]] <= dbus_req.wrdata;
			dut_addr_q.push_back(dbus_req.address);
			dut_data_q.push_back(dbus_req.wrdata);
		end
		if (cpu_core_inst.resolved_branch.taken && cpu_core_inst.resolved_branch.target == end_pc)
			end_seen <= 1'b1;
	end
end

task automatic check_equal(input string what, input logic [31:0] got,
	input logic [31:0] expected);
	checks++;
	if (got !== expected) begin
		errors++;
		$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, expected);
	end
endtask

always @(posedge clk) begin : compare_stores
	int n;
	if (compare_start && !compare_done) begin
		check_equal("store count", dut_addr_q.size(), ref_addr_q.size());
		n = dut_addr_q.size() < ref_addr_q.size() ? dut_addr_q.size() : ref_addr_q.size();
		for (int i = 0; i < n; i++) begin
			check_equal($sformatf("store %0d address", i), dut_addr_q[i], ref_addr_q[i]);
			check_equal($sformatf("store %0d data", i), dut_data_q[i], ref_data_q[i]);
		end
		compare_done <= 1'b1;
	end
end

function automatic cpu_isa_pkg::uint32_t fill_word(int idx);
	return (idx * 4) * 32'h9e37_79b1 ^ 32'h1357_9bdf;
endfunction

task automatic run_test(input string name, input logic delay, input logic stall);
	int cycles;
	int errors_before;
	errors_before = errors;
	ibus_delay_en = delay;
	dbus_stall_en = stall;
	for (int i = 0; i < MEM_WORDS; i++) begin
		ref_dmem[i] = fill_word(i);
		dmem[i] = fill_word(i);
	end
	run_ref();
	dut_addr_q.delete();
	dut_data_q.delete();
	rst <= 1'b1;
	repeat (4) @(posedge clk);
	rst <= 1'b0;
	// first cycle out of reset fetches from address zero
	@(posedge clk);
	check_equal("ibus read after reset", ibus_req.read, 1'b1);
	check_equal("ibus address after reset", ibus_req.address, 32'h0000_0000);
	check_equal("dbus strobes after reset", {dbus_req.read, dbus_req.write}, 2'b00);
	cycles = 0;
	while (!end_seen && cycles < 2000) begin
		@(posedge clk);
		cycles++;
	end
	if (!end_seen) begin
		errors++;
		$display("test %s: the program never reached its final branch", name);
	end else begin
		compare_start <= 1'b1;
		cycles = 0;
		while (!compare_done && cycles < 100) begin
			@(posedge clk);
			cycles++;
		end
		if (!compare_done) begin
			errors++;
			$display("test %s: the store comparison did not finish", name);
		end
		compare_start <= 1'b0;
		compare_done <= 1'b0;
		@(posedge clk);
		$display("test %s: %0d stores, %0d errors", name, ref_addr_q.size(),
			errors - errors_before);
	end
endtask

task automatic build_alu_chain();
	begin_program();
	emit(itype(cpu_isa_pkg::OPC_ADDIU, 0, 1, 5));
	emit(itype(cpu_isa_pkg::OPC_ADDIU, 1, 2, -7));
	emit(rtype(cpu_isa_pkg::FN_ADDU, 1, 2, 3, 0));
	emit(rtype(cpu_isa_pkg::FN_SUBU, 3, 1, 4, 0));
	emit(rtype(cpu_isa_pkg::FN_AND, 3, 4, 5, 0));
	emit(rtype(cpu_isa_pkg::FN_OR, 5, 2, 6, 0));
	emit(rtype(cpu_isa_pkg::FN_XOR, 6, 3, 7, 0));
	emit(itype(cpu_isa_pkg::OPC_LUI, 0, 8, 16'h8001));
	emit(itype(cpu_isa_pkg::OPC_ORI, 8, 8, 16'h1234));
	emit(rtype(cpu_isa_pkg::FN_SLT, 8, 1, 9, 0));
	emit(rtype(cpu_isa_pkg::FN_SLT, 1, 8, 10, 0));
	emit(rtype(cpu_isa_pkg::FN_SLL, 0, 8, 11, 3));
	for (int r = 1; r <= 11; r++)
		store_reg(r, 16'h100 + 4 * r);
	end_program();
endtask

task automatic build_load_use();
	begin_program();
	emit(itype(cpu_isa_pkg::OPC_LW, 0, 1, 16'h10));
	emit(rtype(cpu_isa_pkg::FN_ADDU, 1, 1, 2, 0));
	store_reg(2, 16'h200);
	emit(itype(cpu_isa_pkg::OPC_LW, 0, 3, 16'h14));
	emit(itype(cpu_isa_pkg::OPC_ADDIU, 3, 4, 1));
	store_reg(4, 16'h204);
	emit(itype(cpu_isa_pkg::OPC_LW, 0, 5, 16'h18));
	store_reg(5, 16'h208);
	emit(itype(cpu_isa_pkg::OPC_LW, 0, 6, 16'h208));
	emit(rtype(cpu_isa_pkg::FN_SUBU, 6, 5, 7, 0));
	store_reg(7, 16'h20c);
	end_program();
endtask

task automatic build_branches();
	begin_program();
	emit(itype(cpu_isa_pkg::OPC_ADDIU, 0, 1, 4));
	emit(itype(cpu_isa_pkg::OPC_ADDIU, 0, 2, 0));
	// countdown loop
	emit(itype(cpu_isa_pkg::OPC_ADDIU, 1, 1, -1));
	emit(itype(cpu_isa_pkg::OPC_SW, 2, 1, 16'h300));
	emit(itype(cpu_isa_pkg::OPC_ADDIU, 2, 2, 4));
	emit(itype(cpu_isa_pkg::OPC_BNE, 1, 0, -4));
	emit(itype(cpu_isa_pkg::OPC_BEQ, 1, 0, 1));
	emit(itype(cpu_isa_pkg::OPC_ADDIU, 0, 3, 99));
	store_reg(3, 16'h380);
	emit(itype(cpu_isa_pkg::OPC_BNE, 1, 0, 1));
	emit(itype(cpu_isa_pkg::OPC_ADDIU, 0, 4, 77));
	store_reg(4, 16'h384);
	emit(itype(cpu_isa_pkg::OPC_BEQ, 2, 0, 1));
	emit(itype(cpu_isa_pkg::OPC_ADDIU, 0, 5, 55));
	store_reg(5, 16'h388);
	end_program();
endtask

task automatic build_multiply();
	begin_program();
	emit(itype(cpu_isa_pkg::OPC_LUI, 0, 1, 16'hffff));
	emit(itype(cpu_isa_pkg::OPC_ORI, 1, 1, 16'hfff9));
	emit(itype(cpu_isa_pkg::OPC_LUI, 0, 2, 16'h0001));
	emit(itype(cpu_isa_pkg::OPC_ORI, 2, 2, 16'he240));
	emit(rtype(cpu_isa_pkg::FN_MULT, 1, 2, 0, 0));
	emit(rtype(cpu_isa_pkg::FN_MFHI, 0, 0, 3, 0));
	emit(rtype(cpu_isa_pkg::FN_MFLO, 0, 0, 4, 0));
	store_reg(3, 16'h3c0);
	store_reg(4, 16'h3c4);
	emit(itype(cpu_isa_pkg::OPC_LUI, 0, 5, 16'h7fff));
	emit(itype(cpu_isa_pkg::OPC_ORI, 5, 5, 16'hffff));
	emit(rtype(cpu_isa_pkg::FN_MULT, 5, 5, 0, 0));
	emit(rtype(cpu_isa_pkg::FN_MFLO, 0, 0, 6, 0));
	emit(rtype(cpu_isa_pkg::FN_MFHI, 0, 0, 7, 0));
	store_reg(6, 16'h3c8);
	store_reg(7, 16'h3cc);
	end_program();
endtask

task automatic build_random();
	int rd;
	int rs;
	int rt;
	int off;
	begin_program();
	for (int k = 0; k < 60; k++) begin
		rd = 1 + $urandom % 7;
		rs = 1 + $urandom % 7;
		rt = 1 + $urandom % 7;
		off = ($urandom % 64) * 4;
		case ($urandom % 12)
			0: emit(rtype(cpu_isa_pkg::FN_ADDU, rs, rt, rd, 0));
			1: emit(rtype(cpu_isa_pkg::FN_SUBU, rs, rt, rd, 0));
			2: emit(rtype(cpu_isa_pkg::FN_AND, rs, rt, rd, 0));
			3: emit(rtype(cpu_isa_pkg::FN_OR, rs, rt, rd, 0));
			4: emit(rtype(cpu_isa_pkg::FN_XOR, rs, rt, rd, 0));
			5: emit(rtype(cpu_isa_pkg::FN_SLT, rs, rt, rd, 0));
			6: emit(rtype(cpu_isa_pkg::FN_SLL, 0, rt, rd, $urandom % 32));
			7: emit(itype(cpu_isa_pkg::OPC_ADDIU, rs, rd, $urandom));
			8: emit(itype(cpu_isa_pkg::OPC_ORI, rs, rd, $urandom));
			9: emit(itype(cpu_isa_pkg::OPC_LUI, 0, rd, $urandom));
			10: emit(itype(cpu_isa_pkg::OPC_LW, 0, rd, off));
			default: store_reg(rt, off);
		endcase
	end
	for (int r = 1; r <= 7; r++)
		store_reg(r, 16'h200 + 4 * r);
	end_program();
endtask

initial begin
	void'($urandom(32'h36b11ce8));
	rst = 1'b1;
	ibus_wait = 0;
	dbus_resp.stall = 1'b0;
	dbus_resp.rddata = '0;
	ibus_delay_en = 1'b0;
	dbus_stall_en = 1'b0;
	compare_start = 1'b0;
	compare_done = 1'b0;
	end_pc = '1;
	errors = 0;
	checks = 0;
	build_alu_chain();
	run_test("alu_chain", 1'b0, 1'b0);
	build_load_use();
	run_test("load_use", 1'b1, 1'b0);
	build_branches();
	run_test("branches", 1'b1, 1'b0);
	build_multiply();
	run_test("multiply", 1'b1, 1'b1);
	build_random();
	run_test("random", 1'b1, 1'b1);
	$display("%0d checks, %0d errors", checks, errors);
	if (errors == 0)
		$display("Simulation passed");
	else
		$display("Simulation failed");
	$finish;
end

endmodule

//--- compile.f
hdl/cpu_isa_pkg.sv
hdl/cpu_pipe_pkg.sv
hdl/regfile.sv
hdl/instr_fetch.sv
hdl/decode_issue.sv
hdl/instr_exec.sv
hdl/cpu_core.sv
+incdir+bench
bench/cpu_core_tb.sv
